// ==== Makefile ====
LOG = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run idct_tb and check the log"
	@echo "  clean  remove build output and log"

test:
	verilator --binary --timing --assert -Wno-fatal -f project.f \
		--top-module idct_tb -o sim_idct
	./obj_dir/sim_idct > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "Finished with errors" $(LOG); then \
		echo "simulation failed"; exit 1; \
	fi
	@grep -q "Finished with no errors" $(LOG) || { echo "simulation incomplete"; exit 1; }

clean:
	rm -rf obj_dir $(LOG)

// ==== design/block_buffer.sv ====
`default_nettype none

`include "idct_defines.svh"

module block_buffer #(
    parameter type payload_t = logic [`COEFF_W-1:0]
) (
    input logic   CLOCK,
    buffer_if.ram bus
);

    payload_t mem [`IDCT_ENTRIES];

    // one write port and one read port, the read is registered
    always_ff @(posedge CLOCK) begin
        if (bus.wr_en)
            mem[bus.wr_addr] <= bus.wr_data;
        bus.rd_data <= mem[bus.rd_addr];    // old data on a same-entry collision
    end

endmodule

`default_nettype wire

// ==== design/block_io.sv ====
`default_nettype none

`include "idct_defines.svh"

module block_io import sram_pkg::*, idct_pkg::*; (
    input  logic        CLOCK,
    input  logic        Resetn,
    input  logic        start,
    input  sram_addr_t  coeff_base,
    input  sram_addr_t  pixel_base,
    output sram_addr_t  sram_address,
    output sram_word_t  sram_write_data,
    input  sram_word_t  sram_read_data,
    output logic        sram_we_n,
    buffer_if.writer    coef_wr,
    buffer_if.reader    pix_rd,
    input  logic        store_start,
    output logic        load_done,
    output logic        busy,
    output logic        done
);

    localparam int LAT = `SRAM_READ_LATENCY;

    logic        accept;
    sram_addr_t  row_base;          // column 0 of the coefficient row being read
    sram_addr_t  pix_base_q;
    logic        iss_vld;           // sram_address holds a load address
    entry_idx_t  iss_idx;
    logic        dly_vld [LAT];     // follows each load address until its data returns
    entry_idx_t  dly_idx [LAT];
    logic        st_rd_on;
    entry_idx_t  st_rd_idx;
    logic        st_dvld;           // pix_rd.rd_data is valid
    entry_idx_t  st_didx;
    logic [7:0]  even_px;
    pixel_pair_t pair;
    logic        last_wr;

    function automatic logic [7:0] clip_pixel(input acc_t v);
        acc_t s;
        s = v >>> `PIXEL_SHIFT;
        if (v < 0)
            return 8'd0;
        if (s > 255)
            return 8'd255;
        return s[7:0];
    endfunction

    assign accept = start && !busy;     // start while busy is dropped

    assign coef_wr.wr_en   = dly_vld[LAT-1];
    assign coef_wr.wr_addr = dly_idx[LAT-1];
    assign coef_wr.wr_data = coeff_t'(sram_read_data);
    assign pix_rd.rd_addr  = st_rd_idx;

    always_comb begin
        pair.even = even_px;
        pair.odd  = clip_pixel(pix_rd.rd_data);
    end

    always_ff @(posedge CLOCK or negedge Resetn) begin
        if (!Resetn) begin
            busy      <= 1'b0;
            done      <= 1'b0;
            load_done <= 1'b0;
            iss_vld   <= 1'b0;
            for (int s = 0; s < LAT; s++)
                dly_vld[s] <= 1'b0;
            st_rd_on  <= 1'b0;
            st_dvld   <= 1'b0;
            sram_we_n <= 1'b1;
            last_wr   <= 1'b0;
        end else begin
            if (accept)
                busy <= 1'b1;
            else if (last_wr)
                busy <= 1'b0;
            done <= last_wr;

            if (accept)
                iss_vld <= 1'b1;
            else if (iss_vld && &iss_idx)
                iss_vld <= 1'b0;
            dly_vld[0] <= iss_vld;
            for (int s = 1; s < LAT; s++)
                dly_vld[s] <= dly_vld[s-1];
            load_done <= dly_vld[LAT-1] && &dly_idx[LAT-1];   // 64th word lands now

            if (store_start)
                st_rd_on <= 1'b1;
            else if (st_rd_on && &st_rd_idx)
                st_rd_on <= 1'b0;
            st_dvld   <= st_rd_on;
            sram_we_n <= !(st_dvld && st_didx[0]);  // write on every odd entry
            last_wr   <= st_dvld && &st_didx;
        end
    end

    always_ff @(posedge CLOCK) begin
        if (accept) begin
            sram_address <= coeff_base;
            row_base     <= coeff_base;
            pix_base_q   <= pixel_base;
            iss_idx      <= '0;
        end else if (iss_vld && !(&iss_idx)) begin
            iss_idx <= iss_idx + 1'b1;
            if (&iss_idx[2:0]) begin    // end of a row, jump one stride down
                sram_address <= row_base + sram_addr_t'(`COEFF_ROW_STRIDE);
                row_base     <= row_base + sram_addr_t'(`COEFF_ROW_STRIDE);
            end else begin
                sram_address <= sram_address + 1'b1;
            end
        end else if (st_dvld && st_didx[0]) begin
            sram_address <= pix_base_q
                          + sram_addr_t'(st_didx[5:3]) * sram_addr_t'(`PIXEL_ROW_STRIDE)
                          + sram_addr_t'(st_didx[2:1]);
        end

        dly_idx[0] <= iss_idx;
        for (int s = 1; s < LAT; s++)
            dly_idx[s] <= dly_idx[s-1];

        if (store_start)
            st_rd_idx <= '0;
        else if (st_rd_on)
            st_rd_idx <= st_rd_idx + 1'b1;
        st_didx <= st_rd_idx;

        if (st_dvld && !st_didx[0])
            even_px <= clip_pixel(pix_rd.rd_data);    // hold until its partner arrives
        if (st_dvld && st_didx[0])
            sram_write_data <= pair;
    end

endmodule

`default_nettype wire

// ==== design/buffer_if.sv ====
`default_nettype none

interface buffer_if import idct_pkg::*; #(
    parameter type payload_t = coeff_t
);

    logic       wr_en;
    entry_idx_t wr_addr;
    payload_t   wr_data;
    entry_idx_t rd_addr;
    payload_t   rd_data;    // one cycle after rd_addr

    modport writer (
        output wr_en,
        output wr_addr,
        output wr_data
    );

    modport reader (
        output rd_addr,
        input  rd_data
    );

    modport ram (
        input  wr_en,
        input  wr_addr,
        input  wr_data,
        input  rd_addr,
        output rd_data
    );

endinterface

`default_nettype wire

// ==== design/idct_defines.svh ====
`ifndef IDCT_DEFINES_SVH
`define IDCT_DEFINES_SVH

// block geometry
`define IDCT_N              8
`define IDCT_ENTRIES        64

// datapath widths and scaling
`define COEFF_W             16
`define ACC_W               32
`define PROD_SHIFT          8       // applied to every product before the add
`define PIXEL_SHIFT         16      // final sum to 8-bit pixel

// SRAM layout, in words
`define COEFF_ROW_STRIDE    320
`define PIXEL_ROW_STRIDE    160
`define SRAM_READ_LATENCY   2

`endif

// ==== design/idct_pkg.sv ====
`default_nettype none

`include "idct_defines.svh"

package idct_pkg;

    typedef logic signed [`COEFF_W-1:0]        coeff_t;
    typedef logic signed [`ACC_W-1:0]          acc_t;
    typedef logic signed [15:0]                cos_t;
    typedef logic [$clog2(`IDCT_ENTRIES)-1:0] entry_idx_t;   // {row, col}

    // C[k][j] of the 8-point DCT basis, scaled by 4096
    function automatic cos_t cos_coeff(input logic [2:0] k, input logic [2:0] j);
        logic [6:0] phase;
        logic [4:0] m;
        logic       neg;
        cos_t       mag;
        phase = {3'b000, j, 1'b1} * {4'b0000, k};  // (2j+1)k in units of pi/16
        m     = phase[4:0];                        // period is 32
        if (m > 5'd16)
            m = 5'd0 - m;                          // cos is even
        neg = (m > 5'd8);
        if (neg)
            m = 5'd16 - m;                         // second quadrant flips sign
        case (m[3:0])
            4'd0:    mag = 16'sd2048;
            4'd1:    mag = 16'sd2009;
            4'd2:    mag = 16'sd1892;
            4'd3:    mag = 16'sd1703;
            4'd4:    mag = 16'sd1448;
            4'd5:    mag = 16'sd1138;
            4'd6:    mag = 16'sd784;
            4'd7:    mag = 16'sd400;
            default: mag = 16'sd0;
        endcase
        if (k == 3'd0)
            return 16'sd1448;                      // DC row, 4096/sqrt(8)
        return neg ? -mag : mag;
    endfunction

endpackage

`default_nettype wire

// ==== design/idct_top.sv ====
`default_nettype none

module idct_top import sram_pkg::*, idct_pkg::*; (
    input  logic       CLOCK,
    input  logic       Resetn,
    input  logic       start,
    input  sram_addr_t coeff_base,
    input  sram_addr_t pixel_base,
    output sram_addr_t sram_address,
    output sram_word_t sram_write_data,
    output logic       sram_we_n,
    input  sram_word_t sram_read_data,
    output logic       busy,
    output logic       done
);

    logic load_done;
    logic t_done;       // T = S'*C finished
    logic s_done;       // S = Ct*T finished

    buffer_if #(.payload_t(coeff_t)) coef_bus ();
    buffer_if #(.payload_t(acc_t))   t_bus ();
    buffer_if #(.payload_t(acc_t))   pix_bus ();

    block_io u_io (
        .CLOCK           (CLOCK),
        .Resetn          (Resetn),
        .start           (start),
        .coeff_base      (coeff_base),
        .pixel_base      (pixel_base),
        .sram_address    (sram_address),
        .sram_write_data (sram_write_data),
        .sram_read_data  (sram_read_data),
        .sram_we_n       (sram_we_n),
        .coef_wr         (coef_bus),
        .pix_rd          (pix_bus),
        .store_start     (s_done),
        .load_done       (load_done),
        .busy            (busy),
        .done            (done)
    );

    block_buffer #(.payload_t(coeff_t)) u_coef_buf (
        .CLOCK (CLOCK),
        .bus   (coef_bus)
    );

    block_buffer #(.payload_t(acc_t)) u_t_buf (
        .CLOCK (CLOCK),
        .bus   (t_bus)
    );

    block_buffer #(.payload_t(acc_t)) u_pix_buf (
        .CLOCK (CLOCK),
        .bus   (pix_bus)
    );

    // first pass, coefficients times C
    matrix_pass #(.in_t(coeff_t), .out_t(acc_t), .left_cosine(1'b0)) u_pass_t (
        .CLOCK     (CLOCK),
        .Resetn    (Resetn),
        .start     (load_done),
        .src       (coef_bus),
        .dst       (t_bus),
        .pass_done (t_done)
    );

    // second pass, C transposed times T
    matrix_pass #(.in_t(acc_t), .out_t(acc_t), .left_cosine(1'b1)) u_pass_s (
        .CLOCK     (CLOCK),
        .Resetn    (Resetn),
        .start     (t_done),
        .src       (t_bus),
        .dst       (pix_bus),
        .pass_done (s_done)
    );

endmodule

`default_nettype wire

// ==== design/matrix_pass.sv ====
`default_nettype none

`include "idct_defines.svh"

module matrix_pass import idct_pkg::*; #(
    parameter type in_t        = coeff_t,
    parameter type out_t       = acc_t,
    parameter bit  left_cosine = 1'b0     // 0: In*C, 1: Ct*In
) (
    input  logic     CLOCK,
    input  logic     Resetn,
    input  logic     start,
    buffer_if.reader src,
    buffer_if.writer dst,
    output logic     pass_done
);

    localparam int STAGES = 4;  // address, operand, product, accumulate

    logic              running;
    logic [8:0]        step;                // {i, j, k}
    logic [STAGES:1]   vld;
    logic [8:0]        step_q [1:STAGES];   // step that travels with each stage
    in_t               op_data;
    cos_t              op_cos;
    acc_t              prod;
    acc_t              term;
    acc_t              acc;

    // In*C needs In[i][k], Ct*In needs In[k][j]
    assign src.rd_addr = left_cosine ? {step[2:0], step[5:3]} : {step[8:6], step[2:0]};

    assign term = prod >>> `PROD_SHIFT;

    // element is complete after its eighth term
    assign dst.wr_en   = vld[STAGES] && (step_q[STAGES][2:0] == 3'd7);
    assign dst.wr_addr = step_q[STAGES][8:3];
    assign dst.wr_data = out_t'(acc);

    always_ff @(posedge CLOCK or negedge Resetn) begin
        if (!Resetn) begin
            running   <= 1'b0;
            vld       <= '0;
            pass_done <= 1'b0;
        end else begin
            if (start)
                running <= 1'b1;
            else if (running && &step)
                running <= 1'b0;    // 512 terms issued
            vld       <= {vld[STAGES-1:1], running};
            pass_done <= vld[STAGES] && &step_q[STAGES];
        end
    end

    always_ff @(posedge CLOCK) begin
        if (start)
            step <= '0;
        else if (running)
            step <= step + 1'b1;

        step_q[1] <= step;
        for (int s = 2; s <= STAGES; s++)
            step_q[s] <= step_q[s-1];

        // operand stage, basis value picked for this term
        op_data <= src.rd_data;
        op_cos  <= cos_coeff(step_q[1][2:0], left_cosine ? step_q[1][8:6] : step_q[1][5:3]);

        prod <= acc_t'(op_data) * acc_t'(op_cos);

        if (vld[3]) begin
            if (step_q[3][2:0] == 3'd0)
                acc <= term;        // new element starts here
            else
                acc <= acc + term;
        end
    end

endmodule

`default_nettype wire

// ==== design/sram_pkg.sv ====
`default_nettype none

package sram_pkg;

    typedef logic [17:0] sram_addr_t;
    typedef logic [15:0] sram_word_t;

    // two clipped pixels share one SRAM word
    typedef struct packed {
        logic [7:0] even;   // even column, high byte
        logic [7:0] odd;
    } pixel_pair_t;

endpackage

`default_nettype wire

// ==== project.f ====
+incdir+design
design/sram_pkg.sv
design/idct_pkg.sv
design/buffer_if.sv
design/block_buffer.sv
design/block_io.sv
design/matrix_pass.sv
design/idct_top.sv
tests/idct_assert.sv
tests/idct_tb.sv

// ==== tests/idct_assert.sv ====
`default_nettype none

module idct_assert (
    input logic CLOCK,
    input logic Resetn,
    input logic start,
    input logic busy,
    input logic done,
    input logic sram_we_n,
    input logic load_done
);

    logic loading;  // between an accepted start and load_done

    always_ff @(posedge CLOCK or negedge Resetn) begin
        if (!Resetn)
            loading <= 1'b0;
        else if (start && !busy)
            loading <= 1'b1;
        else if (load_done)
            loading <= 1'b0;
    end

    a_done_pulse: assert property (@(posedge CLOCK) disable iff (!Resetn)
        done |=> !done)
        else $error("done stayed high for two cycles");

    a_no_write_in_load: assert property (@(posedge CLOCK) disable iff (!Resetn)
        loading |-> sram_we_n)
        else $error("SRAM write while a block was loading");

    a_busy_done: assert property (@(posedge CLOCK) disable iff (!Resetn)
        !(busy && done))
        else $error("busy and done high together");

endmodule

`default_nettype wire

// ==== tests/idct_tb.sv ====
`default_nettype none

`include "idct_defines.svh"

module idct_tb import sram_pkg::*, idct_pkg::*; ();

    localparam int PERIOD     = 4;
    localparam int NUM_BLOCKS = 25;
    localparam int MEM_WORDS  = 1 << 18;
    localparam int LAT        = `SRAM_READ_LATENCY;

    logic       CLOCK;
    logic       Resetn;
    logic       start;
    sram_addr_t coeff_base;
    sram_addr_t pixel_base;
    sram_addr_t sram_address;
    sram_word_t sram_write_data;
    sram_word_t sram_read_data;
    logic       sram_we_n;
    logic       busy;
    logic       done;

    sram_word_t  mem [MEM_WORDS];
    sram_word_t  exp_mem [MEM_WORDS];   // what the SRAM should hold
    sram_word_t  rd_pipe [LAT];
    coeff_t      blk [64];
    pixel_pair_t exp_pair [32];
    integer      seed;

    idct_top uut (.*);

    bind idct_top idct_assert u_assert (
        .CLOCK     (CLOCK),
        .Resetn    (Resetn),
        .start     (start),
        .busy      (busy),
        .done      (done),
        .sram_we_n (sram_we_n),
        .load_done (load_done)
    );

    always #(PERIOD / 2) CLOCK = ~CLOCK;

    // SRAM with fixed read latency, a read returns the word from before a same-cycle write
    always @(posedge CLOCK) begin
        rd_pipe[0] <= mem[sram_address];
        for (int s = 1; s < LAT; s++)
            rd_pipe[s] <= rd_pipe[s-1];
        if (!sram_we_n)
            mem[sram_address] = sram_write_data;
    end
    assign sram_read_data = rd_pipe[LAT-1];

    initial begin
        #(NUM_BLOCKS * 1300 * PERIOD + 100 * PERIOD);
        $display("timeout, a block never finished");
        $display("Finished with errors");
        $fatal(1);
    end

    task automatic fail_now();
        $display("Finished with errors");
        $fatal(1);
    endtask

    task automatic check_pixel(input string name, input pixel_pair_t exp, input pixel_pair_t act);
        if (act !== exp) begin
            $display("error %s: expected %h, actual %h", name, exp, act);
            fail_now();
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("error %s: expected %b, actual %b", name, exp, act);
            fail_now();
        end
    endtask

    task automatic check_word(input string name, input sram_word_t exp, input sram_word_t act);
        if (act !== exp) begin
            $display("error %s: expected %h, actual %h", name, exp, act);
            fail_now();
        end
    endtask

    function automatic logic [7:0] to_pixel(input acc_t v);
        if (v < 0)
            return 8'd0;
        if (v / 65536 > 255)
            return 8'd255;
        return 8'(v / 65536);
    endfunction

    // word w of a block holds pixel row w/4, column pair w%4
    function automatic sram_addr_t pixel_word_addr(input sram_addr_t pb, input int w);
        return pb + sram_addr_t'((w / 4) * `PIXEL_ROW_STRIDE + w % 4);
    endfunction

    // T = S'*C, then S = Ct*T, each product scaled down before the add
    task automatic compute_model();
        acc_t t [64];
        acc_t s [64];
        acc_t sum;
        acc_t p;
        for (int i = 0; i < 8; i++)
            for (int j = 0; j < 8; j++) begin
                sum = 0;
                for (int k = 0; k < 8; k++) begin
                    p   = acc_t'(blk[i*8+k]) * acc_t'(cos_coeff(3'(k), 3'(j)));
                    sum = sum + (p >>> `PROD_SHIFT);
                end
                t[i*8+j] = sum;
            end
        for (int i = 0; i < 8; i++)
            for (int j = 0; j < 8; j++) begin
                sum = 0;
                for (int k = 0; k < 8; k++) begin
                    p   = t[k*8+j] * acc_t'(cos_coeff(3'(k), 3'(i)));
                    sum = sum + (p >>> `PROD_SHIFT);
                end
                s[i*8+j] = sum;
            end
        for (int r = 0; r < 8; r++)
            for (int c = 0; c < 4; c++) begin
                exp_pair[r*4+c].even = to_pixel(s[r*8+2*c]);
                exp_pair[r*4+c].odd  = to_pixel(s[r*8+2*c+1]);
            end
    endtask

    task automatic drive_start(input sram_addr_t cb, input sram_addr_t pb);
        @(posedge CLOCK);
        #1;
        start      = 1'b1;
        coeff_base = cb;
        pixel_base = pb;
        @(posedge CLOCK);
        #1;
        start = 1'b0;
    endtask

    task automatic run_block(input string name, input sram_addr_t cb, input sram_addr_t pb,
                             input bit poke_busy);
        sram_addr_t a;
        compute_model();
        for (int r = 0; r < 8; r++)
            for (int c = 0; c < 8; c++) begin
                a          = cb + sram_addr_t'(r * `COEFF_ROW_STRIDE + c);
                mem[a]     = sram_word_t'(blk[r*8+c]);
                exp_mem[a] = sram_word_t'(blk[r*8+c]);
            end
        drive_start(cb, pb);
        @(negedge CLOCK);
        check_flag({name, " busy"}, 1'b1, busy);
        if (poke_busy) begin
            repeat (20) @(negedge CLOCK);
            drive_start(cb + 18'd5, pb + 18'd7);   // must be ignored
        end
        do
            @(negedge CLOCK);
        while (!done);
        check_flag({name, " busy at done"}, 1'b0, busy);
        for (int w = 0; w < 32; w++) begin
            a = pixel_word_addr(pb, w);
            check_pixel(name, exp_pair[w], pixel_pair_t'(mem[a]));
            exp_mem[a] = sram_word_t'(exp_pair[w]);
        end
        for (int i = 0; i < MEM_WORDS; i++)
            if (mem[i] !== exp_mem[i])
                check_word({name, " untouched SRAM"}, exp_mem[i], mem[i]);
    endtask

    task automatic random_block();
        for (int e = 0; e < 64; e++)
            blk[e] = coeff_t'($random(seed) % 513);
    endtask

    initial begin
        sram_addr_t cb;
        sram_addr_t pb;
        seed       = 75;
        CLOCK      = 1'b0;
        Resetn     = 1'b0;
        start      = 1'b0;
        coeff_base = '0;
        pixel_base = '0;
        for (int s = 0; s < LAT; s++)
            rd_pipe[s] <= '0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i]     = sram_word_t'(i * 7 + (i >> 16));   // fill depends on all bits
            exp_mem[i] = mem[i];
        end
        repeat (10) @(posedge CLOCK);
        #1;
        Resetn = 1'b1;

        repeat (10) begin
            @(negedge CLOCK);
            check_flag("idle we_n", 1'b1, sram_we_n);
            check_flag("idle busy", 1'b0, busy);
            check_flag("idle done", 1'b0, done);
        end

        for (int e = 0; e < 64; e++)
            blk[e] = '0;
        blk[0] = 16'sd20000;
        run_block("dc only", 18'd1000, 18'd40000, 1'b0);

        for (int b = 0; b < 20; b++) begin
            random_block();
            cb = sram_addr_t'($unsigned($random(seed)) % (MEM_WORDS - 8 * `COEFF_ROW_STRIDE));
            pb = sram_addr_t'($unsigned($random(seed)) % (MEM_WORDS - 8 * `PIXEL_ROW_STRIDE));
            run_block("random block", cb, pb, 1'b0);
        end

        // column 0 of the basis is all positive, pixel (0,0) clips to 255 and (0,1) to 0
        for (int e = 0; e < 64; e++)
            blk[e] = 16'sd16384;
        run_block("saturate high", 18'd2000, 18'd50000, 1'b0);
        check_pixel("saturate high corner", pixel_pair_t'(16'hff00),
                    pixel_pair_t'(mem[18'd50000]));

        for (int e = 0; e < 64; e++)
            blk[e] = '0;
        blk[0] = -16'sd32768;
        run_block("saturate low", 18'd3000, 18'd60000, 1'b0);
        for (int w = 0; w < 32; w++)
            check_pixel("saturate low all zero", pixel_pair_t'(16'h0000),
                        pixel_pair_t'(mem[pixel_word_addr(18'd60000, w)]));

        random_block();
        run_block("back to back first", 18'd4000, 18'd70000, 1'b1);
        random_block();
        run_block("back to back second", 18'd9000, 18'd80000, 1'b0);

        $display("Finished with no errors");
        $finish;
    end

endmodule

`default_nettype wire
